// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // ####################
    // Sizes
    // ####################

    localparam int XLEN           = 32;
    localparam int NUM_PHYS_REGS  = 64;
    localparam int PHYS_IDX_WIDTH = 6;
    localparam int ARCH_IDX_WIDTH = 5;
    localparam int ROB_ID_WIDTH   = 5;
    localparam int RS_DEPTH       = 8;
    localparam int RS_IDX_WIDTH   = 3;  // Wide enough for an entry index and an entry age.

    // ####################
    // Encodings
    // ####################

    typedef enum logic [1:0] {
        OP1_RS1  = 2'd0,
        OP1_ZERO = 2'd1,
        OP1_PC   = 2'd2
    } op1_sel_t;

    typedef enum logic [1:0] {
        OP2_RS2  = 2'd0,
        OP2_ZERO = 2'd1,
        OP2_IMM  = 2'd2
    } op2_sel_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SRL  = 4'd3,
        ALU_SRA  = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_AND  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // ####################
    // Micro-op formats
    // ####################

    // Renamed micro-op as it arrives from dispatch.
    typedef struct packed {
        alu_op_t                   alu_op;
        op1_sel_t                  op1_sel;
        op2_sel_t                  op2_sel;
        logic [XLEN-1:0]           pc;
        logic [XLEN-1:0]           imm;
        logic [ROB_ID_WIDTH-1:0]   rob_id;
        logic [ARCH_IDX_WIDTH-1:0] rd_arch;
        logic [PHYS_IDX_WIDTH-1:0] rd_phy;
        logic [PHYS_IDX_WIDTH-1:0] rs1_phy;
        logic [PHYS_IDX_WIDTH-1:0] rs2_phy;
    } int_uop_t;

    typedef struct packed {
        alu_op_t                   alu_op;
        op1_sel_t                  op1_sel;
        op2_sel_t                  op2_sel;
        logic [XLEN-1:0]           pc;
        logic [XLEN-1:0]           imm;
        logic [XLEN-1:0]           rs1_value;  // Source values are final at issue.
        logic [XLEN-1:0]           rs2_value;
        logic [ROB_ID_WIDTH-1:0]   rob_id;
        logic [ARCH_IDX_WIDTH-1:0] rd_arch;
        logic [PHYS_IDX_WIDTH-1:0] rd_phy;
    } fu_alu_reg_t;

endpackage

`default_nettype wire

// ==== src/cdb_itf.sv ====
`default_nettype none

interface cdb_itf
    import cpu_pkg::*;
();

    logic                      valid;     // One result per cycle at most.
    logic [ROB_ID_WIDTH-1:0]   rob_id;
    logic [ARCH_IDX_WIDTH-1:0] rd_arch;
    logic [PHYS_IDX_WIDTH-1:0] rd_phy;
    logic [XLEN-1:0]           rd_value;

    // The functional unit drives the bus.
    modport fu (
        output valid,
        output rob_id,
        output rd_arch,
        output rd_phy,
        output rd_value
    );

    modport listen (
        input valid,
        input rob_id,
        input rd_arch,
        input rd_phy,
        input rd_value
    );

endinterface

`default_nettype wire

// ==== src/phys_reg_file.sv ====
`default_nettype none

module phys_reg_file
    import cpu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [PHYS_IDX_WIDTH-1:0] rs1_phy,
    input  logic [PHYS_IDX_WIDTH-1:0] rs2_phy,
    output logic [XLEN-1:0]           rs1_value,
    output logic [XLEN-1:0]           rs2_value,
    output logic                      rs1_ready,
    output logic                      rs2_ready,
    input  logic                      alloc_valid,
    input  logic [PHYS_IDX_WIDTH-1:0] alloc_phy,
    cdb_itf.listen                    cdb
);

    logic [XLEN-1:0]          reg_value [NUM_PHYS_REGS];
    logic [NUM_PHYS_REGS-1:0] reg_ready;

    // ####################
    // Write side
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                reg_value[i] <= '0;
            end
            reg_ready <= '1;
        end else begin
            if (cdb.valid && cdb.rd_phy != '0) begin
                reg_value[cdb.rd_phy] <= cdb.rd_value;
                reg_ready[cdb.rd_phy] <= 1'b1;
            end
            // A new allocation overrides a write to the same register.
            if (alloc_valid && alloc_phy != '0) begin
                reg_ready[alloc_phy] <= 1'b0;
            end
        end
    end

    // ####################
    // Read side
    // ####################

    // Register 0 is never written or allocated, so it stays zero and ready.
    assign rs1_value = reg_value[rs1_phy];
    assign rs2_value = reg_value[rs2_phy];
    assign rs1_ready = reg_ready[rs1_phy];
    assign rs2_ready = reg_ready[rs2_phy];

    // Renaming never hands out register 0.
    a_no_alloc_r0: assert property (@(posedge clk) disable iff (rst)
        alloc_valid |-> alloc_phy != '0);

    // A result aimed at register 0 from the ALU must be the hardwired zero.
    a_no_write_r0: assert property (@(posedge clk) disable iff (rst)
        (cdb.valid && cdb.rd_phy == '0) |-> cdb.rd_value == '0);

endmodule

`default_nettype wire

// ==== src/int_rs.sv ====
`default_nettype none

module int_rs
    import cpu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dispatch_valid,
    output logic                      dispatch_ready,
    input  int_uop_t                  dispatch_uop,
    output logic [PHYS_IDX_WIDTH-1:0] rs1_phy,
    output logic [PHYS_IDX_WIDTH-1:0] rs2_phy,
    input  logic [XLEN-1:0]           rs1_value,
    input  logic [XLEN-1:0]           rs2_value,
    input  logic                      rs1_ready,
    input  logic                      rs2_ready,
    output logic                      alloc_valid,
    output logic [PHYS_IDX_WIDTH-1:0] alloc_phy,
    cdb_itf.listen                    cdb,
    output logic                      issue_valid,
    output fu_alu_reg_t               issue_reg
);

    logic [RS_DEPTH-1:0]     ent_valid;
    logic [RS_DEPTH-1:0]     ent_rs1_rdy;
    logic [RS_DEPTH-1:0]     ent_rs2_rdy;
    logic [RS_IDX_WIDTH-1:0] ent_age [RS_DEPTH];  // Count of younger live entries.
    int_uop_t                ent_uop [RS_DEPTH];
    logic [XLEN-1:0]         ent_rs1_val [RS_DEPTH];
    logic [XLEN-1:0]         ent_rs2_val [RS_DEPTH];

    logic                    accept;
    logic                    has_free;
    logic [RS_IDX_WIDTH-1:0] free_idx;
    logic                    cap_rs1_rdy;
    logic                    cap_rs2_rdy;
    logic [XLEN-1:0]         cap_rs1_val;
    logic [XLEN-1:0]         cap_rs2_val;
    logic [RS_DEPTH-1:0]     wake_rs1;
    logic [RS_DEPTH-1:0]     wake_rs2;
    logic [RS_DEPTH-1:0]     ent_ready;
    logic [RS_DEPTH-1:0]     older_than_issue;
    logic [RS_IDX_WIDTH-1:0] issue_idx;

    // ####################
    // Dispatch and capture
    // ####################

    always_comb begin
        has_free = 1'b0;
        free_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                has_free = 1'b1;
                free_idx = RS_IDX_WIDTH'(i);  // Lowest free slot.
            end
        end
    end

    assign dispatch_ready = has_free;
    assign accept         = dispatch_valid && dispatch_ready;
    assign alloc_valid    = accept;
    assign alloc_phy      = dispatch_uop.rd_phy;
    assign rs1_phy        = dispatch_uop.rs1_phy;
    assign rs2_phy        = dispatch_uop.rs2_phy;

    // A result on the bus this cycle has not reached the register file yet.
    always_comb begin
        cap_rs1_rdy = rs1_ready;
        cap_rs1_val = rs1_value;
        cap_rs2_rdy = rs2_ready;
        cap_rs2_val = rs2_value;
        if (cdb.valid && cdb.rd_phy == dispatch_uop.rs1_phy) begin
            cap_rs1_rdy = 1'b1;
            cap_rs1_val = cdb.rd_value;
        end
        if (cdb.valid && cdb.rd_phy == dispatch_uop.rs2_phy) begin
            cap_rs2_rdy = 1'b1;
            cap_rs2_val = cdb.rd_value;
        end
    end

    // ####################
    // Wakeup and select
    // ####################

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            wake_rs1[i] = cdb.valid && !ent_rs1_rdy[i] && ent_uop[i].rs1_phy == cdb.rd_phy;
            wake_rs2[i] = cdb.valid && !ent_rs2_rdy[i] && ent_uop[i].rs2_phy == cdb.rd_phy;
        end
    end

    assign ent_ready = ent_valid & ent_rs1_rdy & ent_rs2_rdy;

    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (ent_ready[i] && (!issue_valid || ent_age[i] > ent_age[issue_idx])) begin
                issue_valid = 1'b1;
                issue_idx   = RS_IDX_WIDTH'(i);
            end
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            older_than_issue[i] = issue_valid && ent_age[i] > ent_age[issue_idx];
        end
    end

    always_comb begin
        issue_reg.alu_op    = ent_uop[issue_idx].alu_op;
        issue_reg.op1_sel   = ent_uop[issue_idx].op1_sel;
        issue_reg.op2_sel   = ent_uop[issue_idx].op2_sel;
        issue_reg.pc        = ent_uop[issue_idx].pc;
        issue_reg.imm       = ent_uop[issue_idx].imm;
        issue_reg.rs1_value = ent_rs1_val[issue_idx];
        issue_reg.rs2_value = ent_rs2_val[issue_idx];
        issue_reg.rob_id    = ent_uop[issue_idx].rob_id;
        issue_reg.rd_arch   = ent_uop[issue_idx].rd_arch;
        issue_reg.rd_phy    = ent_uop[issue_idx].rd_phy;
    end

    // ####################
    // Entry state
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid   <= '0;
            ent_rs1_rdy <= '0;
            ent_rs2_rdy <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                ent_age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                case ({accept, older_than_issue[i]})
                    2'b10:   ent_age[i] <= ent_age[i] + 1'b1;
                    2'b01:   ent_age[i] <= ent_age[i] - 1'b1;  // A younger entry left.
                    default: ent_age[i] <= ent_age[i];
                endcase
                if (wake_rs1[i]) ent_rs1_rdy[i] <= 1'b1;
                if (wake_rs2[i]) ent_rs2_rdy[i] <= 1'b1;
            end
            if (issue_valid) begin
                ent_valid[issue_idx] <= 1'b0;
            end
            if (accept) begin
                ent_valid[free_idx]   <= 1'b1;
                ent_age[free_idx]     <= '0;
                ent_rs1_rdy[free_idx] <= cap_rs1_rdy;
                ent_rs2_rdy[free_idx] <= cap_rs2_rdy;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (accept && free_idx == RS_IDX_WIDTH'(i)) begin
                ent_uop[i]     <= dispatch_uop;
                ent_rs1_val[i] <= cap_rs1_val;
                ent_rs2_val[i] <= cap_rs2_val;
            end else begin
                if (wake_rs1[i]) ent_rs1_val[i] <= cdb.rd_value;
                if (wake_rs2[i]) ent_rs2_val[i] <= cdb.rd_value;
            end
        end
    end

    // Live entries carry distinct ages, so a single oldest ready entry issues.
    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_age_check
        for (genvar j = i + 1; j < RS_DEPTH; j++) begin : g_age_pair
            a_unique_age: assert property (@(posedge clk) disable iff (rst)
                (ent_valid[i] && ent_valid[j]) |-> ent_age[i] != ent_age[j]);
        end
    end

    // Dispatch is never taken while every entry is live.
    a_accept_not_full: assert property (@(posedge clk) disable iff (rst)
        accept |-> $countones(ent_valid) < RS_DEPTH);

endmodule

`default_nettype wire

// ==== src/fu_alu.sv ====
`default_nettype none

module fu_alu
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        issue_valid,
    input  fu_alu_reg_t issue_reg,
    cdb_itf.fu          cdb
);

    logic                      alu_valid;
    fu_alu_reg_t               alu_reg;
    logic [XLEN-1:0]           op_a;
    logic [XLEN-1:0]           op_b;
    logic [XLEN-1:0]           alu_result;
    logic                      cdb_valid;
    logic [ROB_ID_WIDTH-1:0]   cdb_rob_id;
    logic [ARCH_IDX_WIDTH-1:0] cdb_rd_arch;
    logic [PHYS_IDX_WIDTH-1:0] cdb_rd_phy;
    logic [XLEN-1:0]           cdb_rd_value;

    // ####################
    // Input stage
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= issue_valid;  // The unit takes a new op every cycle.
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            alu_reg <= issue_reg;
        end
    end

    // ####################
    // Compute
    // ####################

    always_comb begin
        case (alu_reg.op1_sel)
            OP1_RS1: op_a = alu_reg.rs1_value;
            OP1_PC:  op_a = alu_reg.pc;
            default: op_a = '0;
        endcase
        case (alu_reg.op2_sel)
            OP2_RS2: op_b = alu_reg.rs2_value;
            OP2_IMM: op_b = alu_reg.imm;
            default: op_b = '0;
        endcase
    end

    // Shifts use only the low five bits of the second operand.
    always_comb begin
        case (alu_reg.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << op_b[4:0];
            ALU_SRL:  alu_result = op_a >> op_b[4:0];
            ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            default:  alu_result = '0;
        endcase
    end

    // ####################
    // CDB output stage
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= alu_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_valid) begin
            cdb_rob_id   <= alu_reg.rob_id;
            cdb_rd_arch  <= alu_reg.rd_arch;
            cdb_rd_phy   <= alu_reg.rd_phy;
            cdb_rd_value <= alu_result;
        end
    end

    assign cdb.valid    = cdb_valid;
    assign cdb.rob_id   = cdb_rob_id;
    assign cdb.rd_arch  = cdb_rd_arch;
    assign cdb.rd_phy   = cdb_rd_phy;
    assign cdb.rd_value = cdb_rd_value;

endmodule

`default_nettype wire

// ==== src/int_exec.sv ====
`default_nettype none

module int_exec
    import cpu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dispatch_valid,
    output logic                      dispatch_ready,
    input  int_uop_t                  dispatch_uop,
    output logic                      cdb_valid,
    output logic [ROB_ID_WIDTH-1:0]   cdb_rob_id,
    output logic [ARCH_IDX_WIDTH-1:0] cdb_rd_arch,
    output logic [PHYS_IDX_WIDTH-1:0] cdb_rd_phy,
    output logic [XLEN-1:0]           cdb_rd_value
);

    logic [PHYS_IDX_WIDTH-1:0] rs1_phy;
    logic [PHYS_IDX_WIDTH-1:0] rs2_phy;
    logic [XLEN-1:0]           rs1_value;
    logic [XLEN-1:0]           rs2_value;
    logic                      rs1_ready;
    logic                      rs2_ready;
    logic                      alloc_valid;
    logic [PHYS_IDX_WIDTH-1:0] alloc_phy;
    logic                      issue_valid;
    fu_alu_reg_t               issue_reg;

    cdb_itf cdb ();

    phys_reg_file i_prf (
        .clk,
        .rst,
        .rs1_phy,
        .rs2_phy,
        .rs1_value,
        .rs2_value,
        .rs1_ready,
        .rs2_ready,
        .alloc_valid,
        .alloc_phy,
        .cdb (cdb.listen)
    );

    int_rs i_rs (
        .clk,
        .rst,
        .dispatch_valid,
        .dispatch_ready,
        .dispatch_uop,
        .rs1_phy,
        .rs2_phy,
        .rs1_value,
        .rs2_value,
        .rs1_ready,
        .rs2_ready,
        .alloc_valid,
        .alloc_phy,
        .cdb (cdb.listen),
        .issue_valid,
        .issue_reg
    );

    fu_alu i_alu (
        .clk,
        .rst,
        .issue_valid,
        .issue_reg,
        .cdb (cdb.fu)
    );

    // Results leave the cluster as they are broadcast inside it.
    assign cdb_valid    = cdb.valid;
    assign cdb_rob_id   = cdb.rob_id;
    assign cdb_rd_arch  = cdb.rd_arch;
    assign cdb_rd_phy   = cdb.rd_phy;
    assign cdb_rd_value = cdb.rd_value;

endmodule

`default_nettype wire

// ==== tb/int_exec_tb.sv ====
`default_nettype none

module int_exec_tb
    import cpu_pkg::*;
();

    localparam int NUM_UOPS       = 300;
    localparam int CHAIN_LEN      = 16;
    localparam int NUM_ROB        = 1 << ROB_ID_WIDTH;
    localparam int TIMEOUT_CYCLES = NUM_UOPS * 20;

    logic                      clk;
    logic                      rst;
    logic                      dispatch_valid;
    logic                      dispatch_ready;
    int_uop_t                  dispatch_uop;
    logic                      cdb_valid;
    logic [ROB_ID_WIDTH-1:0]   cdb_rob_id;
    logic [ARCH_IDX_WIDTH-1:0] cdb_rd_arch;
    logic [PHYS_IDX_WIDTH-1:0] cdb_rd_phy;
    logic [XLEN-1:0]           cdb_rd_value;

    integer                    seed;
    int                        cycle;
    int                        sent;
    int                        live_count;
    int                        done_count;
    logic                      took_last;
    logic                      saw_full;
    logic                      ready_seen;
    logic                      probe_armed;
    logic [ROB_ID_WIDTH-1:0]   probe_rob;
    int                        probe_due;
    logic [PHYS_IDX_WIDTH-1:0] last_rd;
    logic [PHYS_IDX_WIDTH-1:0] free_list [$];
    logic [PHYS_IDX_WIDTH-1:0] arch_map [1 << ARCH_IDX_WIDTH];

    // Model state, per physical register and per rob_id.
    logic [XLEN-1:0]           model_rf [NUM_PHYS_REGS];
    logic                      busy [NUM_PHYS_REGS];
    logic                      free_pending [NUM_PHYS_REGS];
    int_uop_t                  rec_uop [NUM_ROB];
    logic                      live [NUM_ROB];
    logic                      rs1_ok [NUM_ROB];
    logic                      rs2_ok [NUM_ROB];
    logic [XLEN-1:0]           rs1_val [NUM_ROB];
    logic [XLEN-1:0]           rs2_val [NUM_ROB];
    logic [PHYS_IDX_WIDTH-1:0] prev_phy [NUM_ROB];

    int_exec i_dut (
        .clk,
        .rst,
        .dispatch_valid,
        .dispatch_ready,
        .dispatch_uop,
        .cdb_valid,
        .cdb_rob_id,
        .cdb_rd_arch,
        .cdb_rd_phy,
        .cdb_rd_value
    );

    always #50 clk = ~clk;

    // ####################
    // Reporting
    // ####################

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped at the first failure.");
    endtask

    task automatic fail_because(input string why);
        $display("Failure at time %0t: %s", $time, why);
        stop_run();
    endtask

    task automatic value_check(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic tag_check(input string name, input logic [ROB_ID_WIDTH-1:0] got,
                             input logic [ROB_ID_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic phy_check(input string name, input logic [PHYS_IDX_WIDTH-1:0] got,
                             input logic [PHYS_IDX_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic arch_check(input string name, input logic [ARCH_IDX_WIDTH-1:0] got,
                              input logic [ARCH_IDX_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic flag_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // ####################
    // Reference model
    // ####################

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [XLEN-1:0] alu_expected(input int_uop_t u,
                                                     input logic [XLEN-1:0] v1,
                                                     input logic [XLEN-1:0] v2);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [4:0]      sh;
        case (u.op1_sel)
            OP1_RS1: a = v1;
            OP1_PC:  a = u.pc;
            default: a = '0;
        endcase
        case (u.op2_sel)
            OP2_RS2: b = v2;
            OP2_IMM: b = u.imm;
            default: b = '0;
        endcase
        sh = b[4:0];
        case (u.alu_op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return $signed(a) >>> sh;
            ALU_XOR:  return a ^ b;
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:  return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    task automatic retire_result();
        logic [ROB_ID_WIDTH-1:0]   r;
        logic [PHYS_IDX_WIDTH-1:0] p;
        logic [PHYS_IDX_WIDTH-1:0] old;
        r = cdb_rob_id;
        if (!live[r]) fail_because($sformatf("rob_id %0d completed unannounced", r));
        if (!rs1_ok[r] || !rs2_ok[r]) begin
            fail_because($sformatf("rob_id %0d completed before a source producer", r));
        end
        phy_check("cdb_rd_phy", cdb_rd_phy, rec_uop[r].rd_phy);
        arch_check("cdb_rd_arch", cdb_rd_arch, rec_uop[r].rd_arch);
        value_check("cdb_rd_value", cdb_rd_value, alu_expected(rec_uop[r], rs1_val[r], rs2_val[r]));
        p = cdb_rd_phy;
        model_rf[p] = cdb_rd_value;
        busy[p] = 1'b0;
        for (int k = 0; k < NUM_ROB; k++) begin
            if (live[k] && !rs1_ok[k] && rec_uop[k].rs1_phy == p) begin
                rs1_ok[k]  = 1'b1;
                rs1_val[k] = cdb_rd_value;
            end
            if (live[k] && !rs2_ok[k] && rec_uop[k].rs2_phy == p) begin
                rs2_ok[k]  = 1'b1;
                rs2_val[k] = cdb_rd_value;
            end
        end
        live[r] = 1'b0;
        live_count--;
        done_count++;
        // The overwritten mapping is free once its own producer is done too.
        old = prev_phy[r];
        if (old != '0 && busy[old]) free_pending[old] = 1'b1;
        else if (old != '0) free_list.push_back(old);
        if (free_pending[p]) begin
            free_pending[p] = 1'b0;
            free_list.push_back(p);
        end
    endtask

    task automatic note_dispatch();
        int_uop_t                u;
        logic [ROB_ID_WIDTH-1:0] r;
        u = dispatch_uop;
        r = u.rob_id;
        rec_uop[r] = u;
        live[r]    = 1'b1;
        rs1_ok[r]  = !busy[u.rs1_phy];  // A result on the bus this cycle counts as ready.
        rs2_ok[r]  = !busy[u.rs2_phy];
        rs1_val[r] = model_rf[u.rs1_phy];
        rs2_val[r] = model_rf[u.rs2_phy];
        busy[u.rd_phy] = 1'b1;
        live_count++;
        if (probe_armed && r == probe_rob) begin
            probe_due   = cycle + 3;
            probe_armed = 1'b0;
        end
    endtask

    // Outputs are sampled mid-cycle, where they are stable.
    always @(negedge clk) begin : monitor
        cycle++;
        took_last = dispatch_valid && dispatch_ready && !rst;
        if (cycle > TIMEOUT_CYCLES) begin
            fail_because($sformatf("timeout with %0d of %0d micro-ops completed",
                                   done_count, NUM_UOPS));
        end
        if (rst) begin
            flag_check("cdb_valid", cdb_valid, 1'b0);
        end else begin
            if (!ready_seen) flag_check("dispatch_ready", dispatch_ready, 1'b1);
            ready_seen = 1'b1;
            if (!dispatch_ready) begin
                saw_full = 1'b1;
                if (live_count < RS_DEPTH) begin
                    fail_because($sformatf("dispatch_ready low with %0d ops in flight", live_count));
                end
            end
            if (cycle == probe_due) begin
                flag_check("cdb_valid", cdb_valid, 1'b1);
                tag_check("cdb_rob_id", cdb_rob_id, probe_rob);
            end
            if (live_count == 0) flag_check("cdb_valid", cdb_valid, 1'b0);
            if (cdb_valid) retire_result();
            if (took_last) note_dispatch();
        end
    end

    // ####################
    // Stimulus
    // ####################

    task automatic make_uop(input int kind, output int_uop_t u);
        logic [ROB_ID_WIDTH-1:0] rob;
        rob = ROB_ID_WIDTH'(sent);
        while (free_list.size() == 0 || live[rob]) begin
            @(posedge clk);
            #10;
        end
        u.alu_op  = alu_op_t'(pick(10));
        u.op1_sel = op1_sel_t'(pick(3));
        u.op2_sel = op2_sel_t'(pick(3));
        u.pc      = $random(seed);
        u.imm     = $random(seed);
        u.rob_id  = rob;
        u.rd_arch = ARCH_IDX_WIDTH'(1 + pick(31));
        case (kind)
            0: begin
                u.rs1_phy = '0;
                u.rs2_phy = '0;
            end
            1: begin
                u.rs1_phy = last_rd;  // Depends on the op just before.
                u.rs2_phy = arch_map[pick(32)];
                u.op1_sel = OP1_RS1;
            end
            default: begin
                u.rs1_phy = arch_map[pick(32)];
                u.rs2_phy = arch_map[pick(32)];
            end
        endcase
        u.rd_phy = free_list.pop_front();
        prev_phy[rob] = arch_map[u.rd_arch];
        arch_map[u.rd_arch] = u.rd_phy;
        last_rd = u.rd_phy;
        sent++;
    endtask

    task automatic present_uop(input int_uop_t u);
        dispatch_uop   = u;
        dispatch_valid = 1'b1;
        @(posedge clk);
        #10;
        while (!took_last) begin
            @(posedge clk);
            #10;
        end
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (live_count != 0) begin
            @(posedge clk);
            #10;
        end
    endtask

    initial begin : driver
        int_uop_t u;
        clk            = 1'b0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_uop   = '0;
        seed           = 28323;
        cycle          = 0;
        sent           = 0;
        live_count     = 0;
        done_count     = 0;
        took_last      = 1'b0;
        saw_full       = 1'b0;
        ready_seen     = 1'b0;
        probe_armed    = 1'b0;
        probe_due      = -1;
        last_rd        = '0;
        for (int p = 0; p < NUM_PHYS_REGS; p++) begin
            model_rf[p]     = '0;
            busy[p]         = 1'b0;
            free_pending[p] = 1'b0;
            if (p != 0) free_list.push_back(PHYS_IDX_WIDTH'(p));
        end
        foreach (arch_map[a]) arch_map[a] = '0;
        foreach (live[r]) live[r] = 1'b0;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #10;
        end
        // A lone independent op measures the dispatch to CDB latency.
        make_uop(0, u);
        probe_rob   = u.rob_id;
        probe_armed = 1'b1;
        present_uop(u);
        wait_drained();
        for (int i = 0; i < CHAIN_LEN; i++) begin
            make_uop(1, u);
            present_uop(u);
        end
        wait_drained();
        if (!saw_full) fail_because("dispatch_ready never went low under a dependence chain");
        while (sent < NUM_UOPS) begin
            if (pick(4) == 0) begin
                @(posedge clk);
                #10;
            end
            make_uop((pick(3) == 0) ? 1 : 2, u);
            present_uop(u);
        end
        wait_drained();
        if (done_count == NUM_UOPS) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            fail_because($sformatf("only %0d of %0d micro-ops completed", done_count, NUM_UOPS));
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
src/cpu_pkg.sv
src/cdb_itf.sv
src/phys_reg_file.sv
src/int_rs.sv
src/fu_alu.sv
src/int_exec.sv
tb/int_exec_tb.sv
